/* source/nts_engine_pkg.sv */
package nts_engine_pkg;

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------

  localparam int API_DATA_W = 32;
  localparam int COUNTER_W  = 64;

  // Bank codes, carried in the upper address nibble
  localparam logic [3:0] BANK_ENGINE = 4'h0;
  localparam logic [3:0] BANK_DEBUG  = 4'h1;

  // ----------------------------------------------------------------------
  // Identity words
  // ----------------------------------------------------------------------

  // ASCII, first character in the top byte
  localparam logic [API_DATA_W-1:0] CORE_NAME0   = 32'h4e54_535f; // "NTS_"
  localparam logic [API_DATA_W-1:0] CORE_NAME1   = 32'h454e_474e; // "ENGN"
  localparam logic [API_DATA_W-1:0] CORE_VERSION = 32'h302e_3035; // "0.05"
  localparam logic [API_DATA_W-1:0] DEBUG_NAME   = 32'h4442_5547; // "DBUG"

  // ----------------------------------------------------------------------
  // Register map
  // ----------------------------------------------------------------------

  // Engine bank
  localparam logic [7:0] ADDR_NAME0   = 8'h00;
  localparam logic [7:0] ADDR_NAME1   = 8'h01;
  localparam logic [7:0] ADDR_VERSION = 8'h02;
  localparam logic [7:0] ADDR_CTRL    = 8'h08;

  // Debug bank counters, high word here and low word one address up
  localparam logic [7:0] ADDR_DBG_PROCESSED  = 8'h00;
  localparam logic [7:0] ADDR_DBG_BAD_COOKIE = 8'h02;
  localparam logic [7:0] ADDR_DBG_BAD_AUTH   = 8'h04;
  localparam logic [7:0] ADDR_DBG_BAD_KEYID  = 8'h06;
  localparam logic [7:0] ADDR_DBG_ERR_CRYPTO = 8'h20;
  localparam logic [7:0] ADDR_DBG_ERR_TXBUF  = 8'h22;

  localparam logic [7:0] ADDR_DBG_NAME    = 8'h08;
  localparam logic [7:0] ADDR_DBG_SYSTICK = 8'h09;

  // Tick counter starts at one
  localparam logic [API_DATA_W-1:0] SYSTICK_RESET = 32'h0000_0001;

  // ----------------------------------------------------------------------
  // Shared types
  // ----------------------------------------------------------------------

  // External 12-bit API address
  typedef struct packed {
    logic [3:0] bank;
    logic [7:0] regaddr;
  } nts_api_addr_t;

  // Request from the decoder to every bank
  typedef struct packed {
    logic                  we;
    logic [7:0]            addr;
    logic [API_DATA_W-1:0] wdata;
  } nts_bank_req_t;

  // Packet-processing event strobes
  typedef struct packed {
    logic processed;
    logic bad_cookie;
    logic bad_auth;
    logic bad_keyid;
    logic error_crypto;
    logic error_txbuf;
  } nts_events_t;

endpackage

/* source/nts_event_counter.sv */
module nts_event_counter
  import nts_engine_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_areset,

  input  logic                  i_event,
  input  logic                  i_snapshot,

  output logic [API_DATA_W-1:0] o_count_hi,
  output logic [API_DATA_W-1:0] o_count_lo_snap
);

  logic [COUNTER_W-1:0]  count_reg;
  logic [API_DATA_W-1:0] snap_reg;

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      count_reg <= '0;
      snap_reg  <= '0;
    end
    else
    begin
      if (i_event)
        count_reg <= count_reg + COUNTER_W'(1);

      // Takes the count from before this edge's increment
      if (i_snapshot)
        snap_reg <= count_reg[API_DATA_W-1:0];
    end
  end

  assign o_count_hi      = count_reg[COUNTER_W-1:API_DATA_W];
  assign o_count_lo_snap = snap_reg;

endmodule

/* source/nts_api_decoder.sv */
module nts_api_decoder
  import nts_engine_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_areset,

  input  logic                  i_api_cs,
  input  logic                  i_api_we,
  input  nts_api_addr_t         i_api_address,
  input  logic [API_DATA_W-1:0] i_api_write_data,

  input  logic [API_DATA_W-1:0] i_rdata_engine,
  input  logic [API_DATA_W-1:0] i_rdata_debug,

  output nts_bank_req_t         o_req,
  output logic                  o_cs_engine,
  output logic                  o_cs_debug,

  output logic [API_DATA_W-1:0] o_api_read_data,
  output logic                  o_api_read_data_valid,
  output logic                  o_api_busy
);

  logic                  active_reg;
  logic                  valid_reg;
  logic                  cs_engine_reg;
  logic                  cs_debug_reg;
  nts_bank_req_t         req_reg;
  logic [API_DATA_W-1:0] rdata_reg;

  logic                  busy;
  logic                  accept;
  logic [API_DATA_W-1:0] rdata_sel;

  // Busy covers the request cycle and, for reads, the valid cycle
  assign busy   = active_reg | valid_reg;
  assign accept = i_api_cs & ~busy;

  // ----------------------------------------------------------------------
  // Request tracking
  // ----------------------------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      active_reg    <= 1'b0;
      cs_engine_reg <= 1'b0;
      cs_debug_reg  <= 1'b0;
      valid_reg     <= 1'b0;
    end
    else
    begin
      active_reg    <= accept;
      cs_engine_reg <= accept && (i_api_address.bank == BANK_ENGINE);
      cs_debug_reg  <= accept && (i_api_address.bank == BANK_DEBUG);
      valid_reg     <= active_reg && !req_reg.we;
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (accept)
    begin
      req_reg.we    <= i_api_we;
      req_reg.addr  <= i_api_address.regaddr;
      req_reg.wdata <= i_api_write_data;
    end
  end

  // ----------------------------------------------------------------------
  // Read return
  // ----------------------------------------------------------------------

  // Unmapped bank reads as zero
  always_comb
  begin
    rdata_sel = '0;
    if (cs_engine_reg)
      rdata_sel = i_rdata_engine;
    else if (cs_debug_reg)
      rdata_sel = i_rdata_debug;
  end

  always_ff @(posedge i_clk)
  begin
    if (active_reg && !req_reg.we)
      rdata_reg <= rdata_sel;
  end

  assign o_req                 = req_reg;
  assign o_cs_engine           = cs_engine_reg;
  assign o_cs_debug            = cs_debug_reg;
  assign o_api_read_data       = rdata_reg;
  assign o_api_read_data_valid = valid_reg;
  assign o_api_busy            = busy;

endmodule

/* source/nts_engine_regs.sv */
module nts_engine_regs
  import nts_engine_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_areset,

  input  logic                  i_cs,
  input  nts_bank_req_t         i_req,
  output logic [API_DATA_W-1:0] o_rdata,

  output logic                  o_busy
);

  logic ctrl_reg;
  logic ctrl_we;

  assign ctrl_we = i_cs && i_req.we && (i_req.addr == ADDR_CTRL);

  // ----------------------------------------------------------------------
  // Control register
  // ----------------------------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
      ctrl_reg <= 1'b0;
    else if (ctrl_we)
      ctrl_reg <= i_req.wdata[0];
  end

  // Engine stays busy until enabled
  assign o_busy = ~ctrl_reg;

  // ----------------------------------------------------------------------
  // Read mux
  // ----------------------------------------------------------------------

  always_comb
  begin
    o_rdata = '0;
    if (i_cs && !i_req.we)
    begin
      case (i_req.addr)
        ADDR_NAME0:   o_rdata = CORE_NAME0;
        ADDR_NAME1:   o_rdata = CORE_NAME1;
        ADDR_VERSION: o_rdata = CORE_VERSION;
        ADDR_CTRL:    o_rdata = {{(API_DATA_W-1){1'b0}}, ctrl_reg};
        default:      o_rdata = '0;
      endcase
    end
  end

endmodule

/* source/nts_debug_regs.sv */
module nts_debug_regs
  import nts_engine_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_areset,

  input  logic                  i_cs,
  input  nts_bank_req_t         i_req,
  output logic [API_DATA_W-1:0] o_rdata,

  input  nts_events_t           i_events
);

  logic [$bits(nts_events_t)-1:0] ev_vec;
  logic [$bits(nts_events_t)-1:0] snap;
  logic [API_DATA_W-1:0]          cnt_hi [$bits(nts_events_t)];
  logic [API_DATA_W-1:0]          cnt_lo [$bits(nts_events_t)];
  logic [API_DATA_W-1:0]          systick_reg;

  // Index 0 is the processed counter, in struct order upward
  assign ev_vec = {i_events.error_txbuf, i_events.error_crypto, i_events.bad_keyid,
                   i_events.bad_auth, i_events.bad_cookie, i_events.processed};

  // ----------------------------------------------------------------------
  // Event counters
  // ----------------------------------------------------------------------

  for (genvar i = 0; i < $bits(nts_events_t); i++)
  begin : g_counter
    nts_event_counter u_counter (
      .i_clk           (i_clk),
      .i_areset        (i_areset),
      .i_event         (ev_vec[i]),
      .i_snapshot      (snap[i]),
      .o_count_hi      (cnt_hi[i]),
      .o_count_lo_snap (cnt_lo[i])
    );
  end

  // Free-running tick
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
      systick_reg <= SYSTICK_RESET;
    else
      systick_reg <= systick_reg + 32'd1;
  end

  // ----------------------------------------------------------------------
  // Read mux and snapshot strobes
  // ----------------------------------------------------------------------

  // A high-word read freezes the matching low word; writes do nothing here
  always_comb
  begin
    o_rdata = '0;
    snap    = '0;
    if (i_cs && !i_req.we)
    begin
      case (i_req.addr)
        ADDR_DBG_PROCESSED:
        begin
          o_rdata = cnt_hi[0];
          snap[0] = 1'b1;
        end
        ADDR_DBG_PROCESSED + 8'd1:  o_rdata = cnt_lo[0];
        ADDR_DBG_BAD_COOKIE:
        begin
          o_rdata = cnt_hi[1];
          snap[1] = 1'b1;
        end
        ADDR_DBG_BAD_COOKIE + 8'd1: o_rdata = cnt_lo[1];
        ADDR_DBG_BAD_AUTH:
        begin
          o_rdata = cnt_hi[2];
          snap[2] = 1'b1;
        end
        ADDR_DBG_BAD_AUTH + 8'd1:   o_rdata = cnt_lo[2];
        ADDR_DBG_BAD_KEYID:
        begin
          o_rdata = cnt_hi[3];
          snap[3] = 1'b1;
        end
        ADDR_DBG_BAD_KEYID + 8'd1:  o_rdata = cnt_lo[3];
        ADDR_DBG_ERR_CRYPTO:
        begin
          o_rdata = cnt_hi[4];
          snap[4] = 1'b1;
        end
        ADDR_DBG_ERR_CRYPTO + 8'd1: o_rdata = cnt_lo[4];
        ADDR_DBG_ERR_TXBUF:
        begin
          o_rdata = cnt_hi[5];
          snap[5] = 1'b1;
        end
        ADDR_DBG_ERR_TXBUF + 8'd1:  o_rdata = cnt_lo[5];
        ADDR_DBG_NAME:              o_rdata = DEBUG_NAME;
        ADDR_DBG_SYSTICK:           o_rdata = systick_reg;
        default:                    o_rdata = '0;
      endcase
    end
  end

endmodule

/* source/nts_engine.sv */
module nts_engine
  import nts_engine_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_areset,

  // Register API
  input  logic                  i_api_cs,
  input  logic                  i_api_we,
  input  nts_api_addr_t         i_api_address,
  input  logic [API_DATA_W-1:0] i_api_write_data,
  output logic [API_DATA_W-1:0] o_api_read_data,
  output logic                  o_api_read_data_valid,
  output logic                  o_api_busy,

  // Statistics strobes from packet processing
  input  nts_events_t           i_events,

  output logic                  o_busy
);

  // ----------------------------------------------------------------------
  // Internal bus
  // ----------------------------------------------------------------------

  nts_bank_req_t         bank_req;
  logic                  cs_engine;
  logic                  cs_debug;
  logic [API_DATA_W-1:0] rdata_engine;
  logic [API_DATA_W-1:0] rdata_debug;

  // ----------------------------------------------------------------------
  // Instances
  // ----------------------------------------------------------------------

  nts_api_decoder u_decoder (
    .i_clk                 (i_clk),
    .i_areset              (i_areset),
    .i_api_cs              (i_api_cs),
    .i_api_we              (i_api_we),
    .i_api_address         (i_api_address),
    .i_api_write_data      (i_api_write_data),
    .i_rdata_engine        (rdata_engine),
    .i_rdata_debug         (rdata_debug),
    .o_req                 (bank_req),
    .o_cs_engine           (cs_engine),
    .o_cs_debug            (cs_debug),
    .o_api_read_data       (o_api_read_data),
    .o_api_read_data_valid (o_api_read_data_valid),
    .o_api_busy            (o_api_busy)
  );

  // Identity and control bank
  nts_engine_regs u_engine_regs (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .i_cs     (cs_engine),
    .i_req    (bank_req),
    .o_rdata  (rdata_engine),
    .o_busy   (o_busy)
  );

  // Statistics bank
  nts_debug_regs u_debug_regs (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .i_cs     (cs_debug),
    .i_req    (bank_req),
    .o_rdata  (rdata_debug),
    .i_events (i_events)
  );

endmodule

/* tb/tb_nts_engine_tasks.svh */
`ifndef TB_NTS_ENGINE_TASKS_SVH
`define TB_NTS_ENGINE_TASKS_SVH

// ------------------------------------------------------------------------
// Compare tasks
// ------------------------------------------------------------------------

task automatic compare_word(input string name, input logic [API_DATA_W-1:0] got,
                            input logic [API_DATA_W-1:0] exp);
  if (got !== exp)
  begin
    $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    mismatch_count++;
  end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
  if (got !== exp)
  begin
    $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
    mismatch_count++;
  end
endtask

// ------------------------------------------------------------------------
// Event helpers
// ------------------------------------------------------------------------

function automatic nts_events_t event_mask(input int idx);
  nts_events_t m;
  m = '0;
  case (idx)
    0: m.processed    = 1'b1;
    1: m.bad_cookie   = 1'b1;
    2: m.bad_auth     = 1'b1;
    3: m.bad_keyid    = 1'b1;
    4: m.error_crypto = 1'b1;
    default: m.error_txbuf = 1'b1;
  endcase
  return m;
endfunction

function automatic logic [7:0] counter_hi_addr(input int idx);
  case (idx)
    0: return ADDR_DBG_PROCESSED;
    1: return ADDR_DBG_BAD_COOKIE;
    2: return ADDR_DBG_BAD_AUTH;
    3: return ADDR_DBG_BAD_KEYID;
    4: return ADDR_DBG_ERR_CRYPTO;
    default: return ADDR_DBG_ERR_TXBUF;
  endcase
endfunction

// Strobe held high for n sampled edges
task automatic pulse_event(input int idx, input int n);
  @(posedge i_clk);
  i_events <= event_mask(idx);
  repeat (n) @(posedge i_clk);
  i_events <= '0;
  exp_count[idx] = exp_count[idx] + COUNTER_W'(n);
endtask

// ------------------------------------------------------------------------
// API access
// ------------------------------------------------------------------------

// Returns at a falling edge with the API idle
task automatic wait_api_idle();
  int n;
  n = 0;
  @(negedge i_clk);
  while (o_api_busy && n < WAIT_LIMIT)
  begin
    @(negedge i_clk);
    n++;
  end
  if (o_api_busy)
  begin
    $display("Timeout at %0t: API stayed busy", $time);
    timeout_count++;
  end
endtask

// Ends on the edge where the DUT samples the cs pulse
task automatic issue_request(input logic we, input logic [3:0] bank,
                             input logic [7:0] regaddr,
                             input logic [API_DATA_W-1:0] wdata);
  wait_api_idle();
  @(posedge i_clk);
  i_api_cs         <= 1'b1;
  i_api_we         <= we;
  i_api_address    <= '{bank: bank, regaddr: regaddr};
  i_api_write_data <= wdata;
  @(posedge i_clk);
  i_api_cs <= 1'b0;
  i_api_we <= 1'b0;
endtask

task automatic api_write(input logic [3:0] bank, input logic [7:0] regaddr,
                         input logic [API_DATA_W-1:0] wdata);
  issue_request(1'b1, bank, regaddr, wdata);
  wait_api_idle();
endtask

// cycle is the edge count at which the request was sampled
task automatic api_read(input logic [3:0] bank, input logic [7:0] regaddr,
                        output logic [API_DATA_W-1:0] data, output int cycle);
  int n;
  issue_request(1'b0, bank, regaddr, '0);
  @(negedge i_clk);
  cycle = cycle_count;
  n = 0;
  while (!o_api_read_data_valid && n < WAIT_LIMIT)
  begin
    @(negedge i_clk);
    n++;
  end
  if (o_api_read_data_valid)
    data = o_api_read_data;
  else
  begin
    $display("Timeout at %0t: no read data valid for bank %0d register 0x%02h",
             $time, bank, regaddr);
    timeout_count++;
    data = 'x;
  end
endtask

task automatic read_and_compare(input logic [3:0] bank, input logic [7:0] regaddr,
                                input string name, input logic [API_DATA_W-1:0] exp);
  logic [API_DATA_W-1:0] data;
  int                    cycle;
  api_read(bank, regaddr, data, cycle);
  compare_word(name, data, exp);
endtask

// ------------------------------------------------------------------------
// Directed tests
// ------------------------------------------------------------------------

task automatic check_reset_state();
  @(negedge i_clk);
  compare_bit("o_api_busy", o_api_busy, 1'b0);
  compare_bit("o_api_read_data_valid", o_api_read_data_valid, 1'b0);
  compare_bit("o_busy", o_busy, 1'b1);
  read_and_compare(BANK_ENGINE, ADDR_NAME0, "name0", CORE_NAME0);
  read_and_compare(BANK_ENGINE, ADDR_NAME1, "name1", CORE_NAME1);
  read_and_compare(BANK_ENGINE, ADDR_VERSION, "version", CORE_VERSION);
endtask

task automatic check_control();
  logic [API_DATA_W-1:0] val;
  val    = $random(seed);
  val[0] = 1'b1;
  api_write(BANK_ENGINE, ADDR_CTRL, val);
  compare_bit("o_busy", o_busy, 1'b0);
  read_and_compare(BANK_ENGINE, ADDR_CTRL, "ctrl", 32'd1);
  val    = $random(seed);
  val[0] = 1'b0;
  api_write(BANK_ENGINE, ADDR_CTRL, val);
  compare_bit("o_busy", o_busy, 1'b1);
  read_and_compare(BANK_ENGINE, ADDR_CTRL, "ctrl", 32'd0);
endtask

task automatic check_event_counts();
  bit used [21];
  int n;
  for (int i = 0; i < 21; i++)
    used[i] = 1'b0;
  for (int idx = 0; idx < NUM_EVENTS; idx++)
  begin
    do
      n = {$random(seed)} % 20 + 1;
    while (used[n]);
    used[n] = 1'b1;
    pulse_event(idx, n);
  end
  for (int idx = 0; idx < NUM_EVENTS; idx++)
  begin
    read_and_compare(BANK_DEBUG, counter_hi_addr(idx), $sformatf("counter %0d hi", idx),
                     exp_count[idx][COUNTER_W-1:API_DATA_W]);
    read_and_compare(BANK_DEBUG, counter_hi_addr(idx) + 8'd1,
                     $sformatf("counter %0d lo", idx), exp_count[idx][API_DATA_W-1:0]);
  end
endtask

// Low word stays frozen at the value seen by the high-word read
task automatic check_snapshot_hold();
  int                   idx;
  logic [COUNTER_W-1:0] old_count;
  idx       = {$random(seed)} % NUM_EVENTS;
  old_count = exp_count[idx];
  read_and_compare(BANK_DEBUG, counter_hi_addr(idx), "snapshot hi", old_count[63:32]);
  pulse_event(idx, 3);
  read_and_compare(BANK_DEBUG, counter_hi_addr(idx) + 8'd1, "snapshot lo held",
                   old_count[31:0]);
  read_and_compare(BANK_DEBUG, counter_hi_addr(idx), "snapshot hi",
                   exp_count[idx][63:32]);
  read_and_compare(BANK_DEBUG, counter_hi_addr(idx) + 8'd1, "snapshot lo new",
                   old_count[31:0] + 32'd3);
endtask

task automatic check_name_and_tick();
  logic [API_DATA_W-1:0] tick1;
  logic [API_DATA_W-1:0] tick2;
  int                    cycle1;
  int                    cycle2;
  int                    gap;
  read_and_compare(BANK_DEBUG, ADDR_DBG_NAME, "debug name", DEBUG_NAME);
  gap = {$random(seed)} % 10 + 1;
  api_read(BANK_DEBUG, ADDR_DBG_SYSTICK, tick1, cycle1);
  // Tick counts one per edge after the edge that released reset
  compare_word("systick", tick1, SYSTICK_RESET + API_DATA_W'(cycle1 - RESET_CYCLES));
  repeat (gap) @(posedge i_clk);
  api_read(BANK_DEBUG, ADDR_DBG_SYSTICK, tick2, cycle2);
  compare_word("systick delta", tick2 - tick1, API_DATA_W'(cycle2 - cycle1));
endtask

task automatic check_ignored_and_unmapped();
  api_write(BANK_DEBUG, ADDR_DBG_NAME, $random(seed));
  api_write(BANK_DEBUG, ADDR_DBG_PROCESSED + 8'd1, $random(seed));
  read_and_compare(BANK_DEBUG, ADDR_DBG_NAME, "debug name", DEBUG_NAME);
  read_and_compare(BANK_DEBUG, ADDR_DBG_PROCESSED, "counter 0 hi", exp_count[0][63:32]);
  read_and_compare(BANK_DEBUG, ADDR_DBG_PROCESSED + 8'd1, "counter 0 lo",
                   exp_count[0][31:0]);
  // Control write into an unmapped bank must not reach the engine bank
  api_write(4'h7, ADDR_CTRL, 32'd1);
  compare_bit("o_busy", o_busy, 1'b1);
  read_and_compare(4'h7, 8'h00, "unmapped bank", 32'd0);
  read_and_compare(BANK_ENGINE, 8'h03, "unmapped engine register", 32'd0);
  read_and_compare(BANK_DEBUG, 8'h10, "unmapped debug register", 32'd0);
endtask

`endif

/* tb/tb_nts_engine.sv */
module tb_nts_engine
  import nts_engine_pkg::*;
();

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 5;
  localparam int WAIT_LIMIT   = 50;
  localparam int NUM_EVENTS   = 6;

  // ----------------------------------------------------------------------
  // DUT signals
  // ----------------------------------------------------------------------

  logic                  i_clk;
  logic                  i_areset;
  logic                  i_api_cs;
  logic                  i_api_we;
  nts_api_addr_t         i_api_address;
  logic [API_DATA_W-1:0] i_api_write_data;
  nts_events_t           i_events;

  logic [API_DATA_W-1:0] o_api_read_data;
  logic                  o_api_read_data_valid;
  logic                  o_api_busy;
  logic                  o_busy;

  // ----------------------------------------------------------------------
  // Testbench state
  // ----------------------------------------------------------------------

  integer seed;
  int     mismatch_count = 0;
  int     timeout_count  = 0;
  int     cycle_count    = 0;

  // Expected 64-bit count per event, index 0 is processed
  logic [COUNTER_W-1:0] exp_count [NUM_EVENTS];

  nts_engine u_nts_engine (
    .i_clk                 (i_clk),
    .i_areset              (i_areset),
    .i_api_cs              (i_api_cs),
    .i_api_we              (i_api_we),
    .i_api_address         (i_api_address),
    .i_api_write_data      (i_api_write_data),
    .o_api_read_data       (o_api_read_data),
    .o_api_read_data_valid (o_api_read_data_valid),
    .o_api_busy            (o_api_busy),
    .i_events              (i_events),
    .o_busy                (o_busy)
  );

  initial
  begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // Edge count, used to know how far apart two requests were sampled
  always @(posedge i_clk)
    cycle_count <= cycle_count + 1;

  `include "tb_nts_engine_tasks.svh"

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial
  begin
    seed             = 32'hb40ebcda;
    i_areset         = 1'b1;
    i_api_cs         = 1'b0;
    i_api_we         = 1'b0;
    i_api_address    = '0;
    i_api_write_data = '0;
    i_events         = '0;
    for (int i = 0; i < NUM_EVENTS; i++)
      exp_count[i] = '0;

    repeat (RESET_CYCLES) @(posedge i_clk);
    i_areset <= 1'b0;
    @(posedge i_clk);

    check_reset_state();
    check_control();
    check_event_counts();
    check_snapshot_hold();
    check_name_and_tick();
    check_ignored_and_unmapped();

    repeat (2) @(posedge i_clk);
    $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count + timeout_count == 0)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+tb
source/nts_engine_pkg.sv
source/nts_event_counter.sv
source/nts_api_decoder.sv
source/nts_engine_regs.sv
source/nts_debug_regs.sv
source/nts_engine.sv
tb/tb_nts_engine.sv
